//--- filelist.f
source/spi_bank_pkg.sv
source/spi_frame_rx.sv
source/rail_guard.sv
source/reg_arbiter.sv
source/reg_bank.sv
source/spi_port_mux.sv
source/spi_ctrl_top.sv
verification/spi_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module spi_ctrl_tb -o spi_ctrl_sim \
  && ./obj_dir/spi_ctrl_sim | tee /dev/stderr | grep -q "^Test OK$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verification/spi_ctrl_tb.sv
`timescale 1ns/1ps
/* testbench for the board-control subsystem
   bit-bangs host frames, keeps a register model and checks the pins
   against it with concurrent assertions, rails and port mux included */
module spi_ctrl_tb;
  import spi_bank_pkg::*;

  localparam int         PORTS        = 8;
  localparam logic [7:0] CS_POL       = 8'b0000_0001;
  localparam int         GUARD_CYCLES = 16;

  logic             cs = 1'b0;
  logic             rst_n;
  logic             spi_ss;
  logic             spi_ss2;
  logic             spi_sclk;
  logic             spi_mosi;
  logic             rails_ok;
  logic [PORTS-1:0] port_miso;
  logic             spi_miso;
  logic [3:0]       led;
  logic             oe_4094;
  logic [3:0]       adc_ctl;
  logic [PORTS-1:0] port_ss;
  logic [PORTS-1:0] port_sclk;
  logic [PORTS-1:0] port_mosi;

  // register model
  logic [3:0]  m_led;
  logic [3:0]  m_4094;
  logic [3:0]  m_adc;
  logic [7:0]  m_mux;
  // check enables and readback capture
  logic        chk_regs;
  logic        rb_chk;
  logic [7:0]  rb_exp;
  logic [7:0]  rb_got;
  logic [31:0] lfsr_state = 32'hfdb7;
  // expected port side
  logic [PORTS-1:0] exp_en;
  logic [PORTS-1:0] exp_act;
  logic [PORTS-1:0] exp_ss;
  logic             exp_miso;

  spi_ctrl_top #(
    .PORTS        (PORTS),
    .CS_POLARITY  (CS_POL),
    .GUARD_CYCLES (GUARD_CYCLES)
  ) DUT (
    .cs (cs), .rst_n (rst_n), .spi_ss (spi_ss), .spi_ss2 (spi_ss2),
    .spi_sclk (spi_sclk), .spi_mosi (spi_mosi), .rails_ok (rails_ok),
    .port_miso (port_miso), .spi_miso (spi_miso), .led (led), .oe_4094 (oe_4094),
    .adc_ctl (adc_ctl), .port_ss (port_ss), .port_sclk (port_sclk), .port_mosi (port_mosi)
  );

  always #5 cs = ~cs;

  ////////////////////////////////////////
  // helpers

  task automatic report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
    $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout, %s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // n rising edges, then 1 ns into the cycle
  task automatic idle(input int n);
    repeat (n) @(posedge cs);
    #1;
  endtask

  // galois form, taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      lfsr_step = (s >> 1) ^ 32'h8020_0003;
    else
      lfsr_step = s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    repeat (n)
    begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  ////////////////////////////////////////
  // register model

  // a bit named in both nibbles makes the whole write a toggle
  function automatic logic [3:0] apply_update(input logic [3:0] cur, input logic [7:0] val);
    logic toggle_mode;
    logic [3:0] res;
    toggle_mode = 1'b0;
    res = cur;
    for (int i = 0; i < 4; i++)
      if (val[i] && val[i+4])
        toggle_mode = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      if (toggle_mode)
        res[i] = (val[i] && val[i+4]) ? !cur[i] : cur[i];
      else if (val[i])
        res[i] = 1'b1;
      else if (val[i+4])
        res[i] = 1'b0;
    end
    apply_update = res;
  endfunction

  function automatic logic [7:0] model_read(input logic [7:0] addr);
    if (addr == REG_LED)
      model_read = {4'h0, m_led};
    else if (addr == REG_4094)
      model_read = {4'h0, m_4094};
    else if (addr == REG_ADC)
      model_read = {4'h0, m_adc};
    else if (addr == REG_SPI_MUX)
      model_read = m_mux;
    else
      model_read = 8'h00;
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
    if (addr == REG_LED)
      m_led = apply_update(m_led, data);
    else if (addr == REG_4094)
      m_4094 = apply_update(m_4094, data);
    else if (addr == REG_ADC)
      m_adc = apply_update(m_adc, data);
    else if (addr == REG_SPI_MUX)
      m_mux = data;
    else if (addr == CMD_SOFT_RESET)
    begin
      m_led  = '0;
      m_4094 = '0;
      m_adc  = '0;
      m_mux  = '0;
    end
    else if (addr == CMD_POWERUP)
    begin
      m_led = '0;
      m_adc = '0;
    end
  endtask

  // mux value n picks port n-1, 0 and anything above PORTS pick none
  always_comb
  begin
    for (int i = 0; i < PORTS; i++)
      exp_en[i] = (m_mux == 8'(i + 1));
  end

  // active-high ports follow the select, the rest see it inverted
  assign exp_act  = exp_en & {PORTS{!spi_ss2}};
  assign exp_ss   = (exp_act & CS_POL) | (~exp_act & ~CS_POL);
  assign exp_miso = |(exp_en & port_miso);

  ////////////////////////////////////////
  // checks

  a_led: assert property (@(posedge cs) disable iff (!rst_n) !chk_regs || led == m_led)
    else report_mismatch("led", {4'h0, m_led}, {4'h0, led});
  a_adc: assert property (@(posedge cs) disable iff (!rst_n) !chk_regs || adc_ctl == m_adc)
    else report_mismatch("adc_ctl", {4'h0, m_adc}, {4'h0, adc_ctl});
  a_oe: assert property (@(posedge cs) disable iff (!rst_n) !chk_regs || oe_4094 == m_4094[0])
    else report_mismatch("oe_4094", {7'h0, m_4094[0]}, {7'h0, oe_4094});
  a_readback: assert property (@(posedge cs) disable iff (!rst_n) !rb_chk || rb_got == rb_exp)
    else report_mismatch("spi_miso readback", rb_exp, rb_got);
  a_port_ss: assert property (@(posedge cs) disable iff (!rst_n) port_ss == exp_ss)
    else report_mismatch("port_ss", exp_ss, port_ss);
  a_port_sclk: assert property (@(posedge cs) disable iff (!rst_n)
    port_sclk == (exp_en & {PORTS{spi_sclk}}))
    else report_mismatch("port_sclk", exp_en & {PORTS{spi_sclk}}, port_sclk);
  a_port_mosi: assert property (@(posedge cs) disable iff (!rst_n)
    port_mosi == (exp_en & {PORTS{spi_mosi}}))
    else report_mismatch("port_mosi", exp_en & {PORTS{spi_mosi}}, port_mosi);
  // ss2 low hands miso to the selected port
  a_miso: assert property (@(posedge cs) disable iff (!rst_n) spi_ss2 || spi_miso == exp_miso)
    else report_mismatch("spi_miso", {7'h0, exp_miso}, {7'h0, spi_miso});

  ////////////////////////////////////////
  // host side stimulus

  // sclk at cs/10, data set on the fall, readback taken at the end of each high phase
  task automatic spi_xfer(input logic [23:0] word, input int nbits, output logic [7:0] rb);
    rb = '0;
    spi_ss = 1'b0;
    idle(5);
    for (int b = 0; b < nbits; b++)
    begin
      spi_mosi = word[nbits-1-b];
      idle(5);
      spi_sclk = 1'b1;
      idle(5);
      if (b >= 7 && b <= 14)
        rb = {rb[6:0], spi_miso};
      spi_sclk = 1'b0;
    end
    idle(5);
    spi_mosi = 1'b0;
    spi_ss = 1'b1;
  endtask

  // full frame, readback checked against the value before the write
  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] rb;
    rb_exp = model_read(addr);
    spi_xfer({8'h00, addr, data}, 16, rb);
    rb_got   = rb;
    rb_chk   = 1'b1;
    chk_regs = 1'b0;
    model_write(addr, data);
    idle(1);
    rb_chk = 1'b0;
    // lands within 5 cycles of ss rising
    idle(5);
    chk_regs = 1'b1;
  endtask

  task automatic update_sweep(input int count);
    logic [31:0] r;
    logic [7:0]  addr;
    repeat (count)
    begin
      rand_bits(10, r);
      case (r[9:8])
        2'd1:    addr = REG_4094;
        2'd2:    addr = REG_ADC;
        default: addr = REG_LED;
      endcase
      write_reg(addr, r[7:0]);
    end
  endtask

  // led address up front, model untouched
  task automatic short_frame(input int nbits);
    logic [31:0] r;
    logic [7:0]  rb;
    rand_bits(16, r);
    spi_xfer({REG_LED, r[15:0]} >> (24 - nbits), nbits, rb);
    idle(8);
  endtask

  task automatic exercise_ports(input int cycles);
    logic [31:0] r;
    spi_ss2 = 1'b0;
    repeat (cycles)
    begin
      rand_bits(10, r);
      spi_sclk  = r[0];
      spi_mosi  = r[1];
      port_miso = r[9:2];
      idle(1);
    end
    spi_ss2   = 1'b1;
    spi_sclk  = 1'b0;
    spi_mosi  = 1'b0;
    port_miso = '0;
    idle(2);
  endtask

  ////////////////////////////////////////
  // rails

  task automatic long_drop();
    int n;
    chk_regs = 1'b0;
    rails_ok = 1'b0;
    n = 0;
    while ((led != 4'h0 || adc_ctl != 4'h0) && n < GUARD_CYCLES + 6)
    begin
      idle(1);
      n++;
      if (n == GUARD_CYCLES + 4)
        rails_ok = 1'b1;
    end
    rails_ok = 1'b1;
    if (led != 4'h0 || adc_ctl != 4'h0)
      abort_on_timeout("rail guard did not clear led and adc_ctl");
    else
    begin
      m_led = '0;
      m_adc = '0;
      idle(4);
      chk_regs = 1'b1;
    end
  endtask

  // glitch, registers must hold
  task automatic short_drop();
    rails_ok = 1'b0;
    idle(GUARD_CYCLES - 3);
    rails_ok = 1'b1;
    idle(GUARD_CYCLES + 8);
  endtask

  ////////////////////////////////////////
  // sequence

  initial
  begin
    rst_n     = 1'b0;
    spi_ss    = 1'b1;
    spi_ss2   = 1'b1;
    spi_sclk  = 1'b0;
    spi_mosi  = 1'b0;
    rails_ok  = 1'b1;
    port_miso = '0;
    chk_regs  = 1'b0;
    rb_chk    = 1'b0;
    rb_exp    = '0;
    rb_got    = '0;
    m_led = LED_RESET;
    m_4094 = '0;
    m_adc = '0;
    m_mux = '0;
    idle(5);
    rst_n = 1'b1;
    idle(2);
    chk_regs = 1'b1;

    // reset values, led reads back 00000001
    write_reg(REG_LED, 8'h00);

    update_sweep(16);
    write_reg(REG_LED, 8'h00);
    write_reg(REG_4094, 8'h00);
    write_reg(REG_ADC, 8'h00);

    // every mux value, two past the last port
    for (int v = 0; v < 10; v++)
    begin
      write_reg(REG_SPI_MUX, 8'(v));
      exercise_ports(12);
    end

    short_frame(12);
    short_frame(20);
    write_reg(REG_LED, 8'h00);

    // soft reset clears everything
    write_reg(REG_LED, 8'h0e);
    write_reg(REG_4094, 8'h03);
    write_reg(REG_ADC, 8'h0a);
    write_reg(REG_SPI_MUX, 8'h03);
    write_reg(CMD_SOFT_RESET, 8'h5a);
    exercise_ports(6);

    // powerup keeps 4094 and mux
    write_reg(REG_LED, 8'h06);
    write_reg(REG_4094, 8'h01);
    write_reg(REG_ADC, 8'h0c);
    write_reg(REG_SPI_MUX, 8'h01);
    write_reg(CMD_POWERUP, 8'hff);
    exercise_ports(6);

    write_reg(REG_LED, 8'h09);
    write_reg(REG_ADC, 8'h05);
    short_drop();
    long_drop();
    exercise_ports(6);
    write_reg(REG_LED, 8'h00);

    $display("Test OK");
    $finish;
  end

endmodule

//--- source/spi_ctrl_top.sv
`timescale 1ns/1ps
/* board-control subsystem top
   host SPI register access, rail guard, write arbitration,
   control register bank and the secondary SPI port mux */
module spi_ctrl_top #(
  parameter int               PORTS        = 8,
  parameter logic [PORTS-1:0] CS_POLARITY  = PORTS'(1),
  parameter int               GUARD_CYCLES = 16
) (
  input  logic                           cs,
  input  logic                           rst_n,
  input  logic                           spi_ss,
  input  logic                           spi_ss2,
  input  logic                           spi_sclk,
  input  logic                           spi_mosi,
  input  logic                           rails_ok,
  input  logic [PORTS-1:0]               port_miso,
  output logic                           spi_miso,
  output logic [spi_bank_pkg::NIB_W-1:0] led,
  output logic                           oe_4094,
  output logic [spi_bank_pkg::NIB_W-1:0] adc_ctl,
  output logic [PORTS-1:0]               port_ss,
  output logic [PORTS-1:0]               port_sclk,
  output logic [PORTS-1:0]               port_mosi
);
  import spi_bank_pkg::*;

  // receiver side
  logic              rx_wr;
  logic [ADDR_W-1:0] rx_addr;
  logic [DATA_W-1:0] rx_data;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              miso_int;
  // guard request
  logic              guard_wr;
  // bank write port
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] mux_sel;

  ////////////////////////////////////////
  // writers

  spi_frame_rx u_frame_rx (
    .cs       (cs),
    .rst_n    (rst_n),
    .spi_ss   (spi_ss),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .rd_data  (rd_data),
    .rd_addr  (rd_addr),
    .rx_wr    (rx_wr),
    .rx_addr  (rx_addr),
    .rx_data  (rx_data),
    .miso_int (miso_int)
  );

  rail_guard #(
    .GUARD_CYCLES (GUARD_CYCLES)
  ) u_rail_guard (
    .cs       (cs),
    .rst_n    (rst_n),
    .rails_ok (rails_ok),
    .guard_wr (guard_wr)
  );

  reg_arbiter u_arbiter (
    .cs       (cs),
    .rst_n    (rst_n),
    .rx_wr    (rx_wr),
    .rx_addr  (rx_addr),
    .rx_data  (rx_data),
    .guard_wr (guard_wr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  ////////////////////////////////////////
  // registers and port routing

  reg_bank u_bank (
    .cs      (cs),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .led     (led),
    .oe_4094 (oe_4094),
    .adc_ctl (adc_ctl),
    .mux_sel (mux_sel)
  );

  // shares sclk and mosi with the host frame pins
  spi_port_mux #(
    .PORTS       (PORTS),
    .CS_POLARITY (CS_POLARITY)
  ) u_port_mux (
    .mux_sel   (mux_sel),
    .spi_ss2   (spi_ss2),
    .spi_sclk  (spi_sclk),
    .spi_mosi  (spi_mosi),
    .port_miso (port_miso),
    .miso_int  (miso_int),
    .port_ss   (port_ss),
    .port_sclk (port_sclk),
    .port_mosi (port_mosi),
    .spi_miso  (spi_miso)
  );

endmodule

//--- source/spi_port_mux.sv
`timescale 1ns/1ps
/* secondary SPI port router, purely combinational
   sends ss2, sclk and mosi to the port picked by the mux register
   and returns that port's miso, or the bank's own miso outside ss2 */
module spi_port_mux #(
  parameter int               PORTS       = 8,
  parameter logic [PORTS-1:0] CS_POLARITY = PORTS'(1)
) (
  input  logic [spi_bank_pkg::DATA_W-1:0] mux_sel,
  input  logic                            spi_ss2,
  input  logic                            spi_sclk,
  input  logic                            spi_mosi,
  input  logic [PORTS-1:0]                port_miso,
  input  logic                            miso_int,
  output logic [PORTS-1:0]                port_ss,
  output logic [PORTS-1:0]                port_sclk,
  output logic [PORTS-1:0]                port_mosi,
  output logic                            spi_miso
);
  import spi_bank_pkg::*;

  logic [PORTS-1:0] port_en;
  logic [PORTS-1:0] ss_act;

  ////////////////////////////////////////
  // port decode

  // 0 is no port, n is port n-1, above PORTS is no port
  always_comb
  begin
    port_en = '0;
    for (int i = 0; i < PORTS; i++)
      port_en[i] = (mux_sel == DATA_W'(i + 1));
  end

  ////////////////////////////////////////
  // outputs to ports

  // ss2 is active low from the host
  assign ss_act = port_en & {PORTS{~spi_ss2}};

  // active-high ports pass the select straight, others invert
  // unselected ports sit at their idle level
  assign port_ss = ~(ss_act ^ CS_POLARITY);

  // idle ports see 0 on clock and data
  assign port_sclk = port_en & {PORTS{spi_sclk}};
  assign port_mosi = port_en & {PORTS{spi_mosi}};

  ////////////////////////////////////////
  // miso return

  // no port selected reads 0 during ss2
  assign spi_miso = spi_ss2 ? miso_int : |(port_en & port_miso);

  // two ports driven at once would short their miso lines
  always_comb
  begin
    a_en_onehot: assert ($onehot0(port_en))
      else $error("port enable not one-hot");
  end

endmodule

//--- source/reg_bank.sv
`timescale 1ns/1ps
/* board control registers
   led, 4094 and adc nibbles with set/clear/toggle update, raw spi mux byte,
   powerup and soft reset commands, combinational readback */
module reg_bank (
  input  logic                            cs,
  input  logic                            rst_n,
  input  logic                            wr_en,
  input  logic [spi_bank_pkg::ADDR_W-1:0] wr_addr,
  input  logic [spi_bank_pkg::DATA_W-1:0] wr_data,
  input  logic [spi_bank_pkg::ADDR_W-1:0] rd_addr,
  output logic [spi_bank_pkg::DATA_W-1:0] rd_data,
  output logic [spi_bank_pkg::NIB_W-1:0]  led,
  output logic                            oe_4094,
  output logic [spi_bank_pkg::NIB_W-1:0]  adc_ctl,
  output logic [spi_bank_pkg::DATA_W-1:0] mux_sel
);
  import spi_bank_pkg::*;

  logic [NIB_W-1:0]  led_q;
  logic [NIB_W-1:0]  r4094_q;
  logic [NIB_W-1:0]  adc_q;
  logic [DATA_W-1:0] mux_q;

  ////////////////////////////////////////
  // set/clear/toggle

  // low nibble sets, high nibble clears
  // any bit named in both turns the write into a pure toggle
  function automatic logic [NIB_W-1:0] nib_update(
    input logic [NIB_W-1:0]  cur,
    input logic [DATA_W-1:0] val
  );
    logic [NIB_W-1:0] set_b;
    logic [NIB_W-1:0] clr_b;
    logic [NIB_W-1:0] both_b;
    set_b  = val[NIB_W-1:0];
    clr_b  = val[2*NIB_W-1:NIB_W];
    both_b = set_b & clr_b;
    if (|both_b)
      nib_update = cur ^ both_b;
    else
      nib_update = (cur | set_b) & ~clr_b;
  endfunction

  ////////////////////////////////////////
  // register writes

  // other addresses leave every register alone
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      led_q   <= LED_RESET;
      r4094_q <= '0;
      adc_q   <= '0;
      mux_q   <= '0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        REG_LED:     led_q   <= nib_update(led_q, wr_data);
        REG_4094:    r4094_q <= nib_update(r4094_q, wr_data);
        REG_ADC:     adc_q   <= nib_update(adc_q, wr_data);
        // mux is a plain byte
        REG_SPI_MUX: mux_q   <= wr_data;
        CMD_SOFT_RESET:
        begin
          led_q   <= '0;
          r4094_q <= '0;
          adc_q   <= '0;
          mux_q   <= '0;
        end
        // rails coming up, 4094 and mux untouched
        CMD_POWERUP:
        begin
          led_q <= '0;
          adc_q <= '0;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // readback

  always_comb
  begin
    case (rd_addr)
      REG_LED:     rd_data = DATA_W'(led_q);
      REG_SPI_MUX: rd_data = mux_q;
      REG_4094:    rd_data = DATA_W'(r4094_q);
      REG_ADC:     rd_data = DATA_W'(adc_q);
      // commands and unknown addresses read 0
      default:     rd_data = '0;
    endcase
  end

  assign led     = led_q;
  assign adc_ctl = adc_q;
  assign mux_sel = mux_q;
  // output enable is the low bit only
  assign oe_4094 = r4094_q[0];

endmodule

//--- source/reg_arbiter.sv
`timescale 1ns/1ps
/* write port arbiter for the register bank
   merges frame receiver writes and rail guard commands, guard first,
   one registered write per cycle, losing request held one cycle */
module reg_arbiter (
  input  logic                            cs,
  input  logic                            rst_n,
  input  logic                            rx_wr,
  input  logic [spi_bank_pkg::ADDR_W-1:0] rx_addr,
  input  logic [spi_bank_pkg::DATA_W-1:0] rx_data,
  input  logic                            guard_wr,
  output logic                            wr_en,
  output logic [spi_bank_pkg::ADDR_W-1:0] wr_addr,
  output logic [spi_bank_pkg::DATA_W-1:0] wr_data
);
  import spi_bank_pkg::*;

  logic              g_pend;
  logic              r_pend;
  logic [ADDR_W-1:0] r_addr_q;
  logic [DATA_W-1:0] r_data_q;
  logic              g_req;
  logic              r_req;
  logic              g_gnt;
  logic              r_gnt;
  logic [ADDR_W-1:0] r_addr;
  logic [DATA_W-1:0] r_data;

  // new pulse or one left over
  assign g_req = guard_wr | g_pend;
  assign r_req = rx_wr | r_pend;

  // fixed priority
  assign g_gnt = g_req;
  assign r_gnt = r_req & ~g_req;

  // receiver payload, live on the pulse cycle
  assign r_addr = rx_wr ? rx_addr : r_addr_q;
  assign r_data = rx_wr ? rx_data : r_data_q;

  ////////////////////////////////////////
  // pending flags

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      g_pend <= 1'b0;
      r_pend <= 1'b0;
    end
    else
    begin
      g_pend <= g_req & ~g_gnt;
      r_pend <= r_req & ~r_gnt;
    end
  end

  always_ff @(posedge cs)
  begin
    if (rx_wr)
    begin
      r_addr_q <= rx_addr;
      r_data_q <= rx_data;
    end
  end

  ////////////////////////////////////////
  // bank write port

  always_ff @(posedge cs)
  begin
    if (!rst_n)
      wr_en <= 1'b0;
    else
      wr_en <= g_gnt | r_gnt;
  end

  // guard has no payload, just the command address
  always_ff @(posedge cs)
  begin
    wr_addr <= g_gnt ? CMD_POWERUP : r_addr;
    wr_data <= g_gnt ? '0 : r_data;
  end

  a_wr_has_req: assert property (@(posedge cs) disable iff (!rst_n)
    wr_en |-> $past(guard_wr || rx_wr || g_pend || r_pend))
    else $error("wr_en without a pending request");

  // no frame write is ever lost to the guard
  a_rx_served: assert property (@(posedge cs) disable iff (!rst_n)
    rx_wr |-> ##[1:2] (wr_en && wr_addr == $past(rx_addr, 1)) or
              ##[1:2] (wr_en && wr_addr == $past(rx_addr, 2)))
    else $error("frame write dropped");

endmodule

//--- source/rail_guard.sv
`timescale 1ns/1ps
/* rail monitor, second writer to the register bank
   requests the powerup safe command once per sustained rails_ok drop */
module rail_guard #(
  parameter int GUARD_CYCLES = 16
) (
  input  logic cs,
  input  logic rst_n,
  input  logic rails_ok,
  output logic guard_wr
);

  localparam int CNT_W = $clog2(GUARD_CYCLES + 1);

  logic [1:0]       rails_q;
  logic             rails_s;
  logic [CNT_W-1:0] low_cnt;
  logic             armed;

  // two-stage sync, rails assumed good out of reset
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      rails_q <= '1;
    else
      rails_q <= {rails_q[0], rails_ok};
  end

  assign rails_s = rails_q[1];

  ////////////////////////////////////////
  // low-time filter

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      low_cnt  <= '0;
      armed    <= 1'b1;
      guard_wr <= 1'b0;
    end
    else if (rails_s)
    begin
      // recovered, re-arm
      low_cnt  <= '0;
      armed    <= 1'b1;
      guard_wr <= 1'b0;
    end
    else
    begin
      if (low_cnt != CNT_W'(GUARD_CYCLES))
        low_cnt <= low_cnt + 1'b1;
      // fires on the GUARD_CYCLES-th low cycle
      guard_wr <= armed && (low_cnt == CNT_W'(GUARD_CYCLES - 1));
      if (low_cnt == CNT_W'(GUARD_CYCLES - 1))
        armed <= 1'b0;
    end
  end

endmodule

//--- source/spi_frame_rx.sv
`timescale 1ns/1ps
/* host SPI slave for the control register bank
   oversamples ss, sclk and mosi on cs, assembles address/value frames
   and shifts the addressed register back out during the value byte */
module spi_frame_rx (
  input  logic                            cs,
  input  logic                            rst_n,
  input  logic                            spi_ss,
  input  logic                            spi_sclk,
  input  logic                            spi_mosi,
  input  logic [spi_bank_pkg::DATA_W-1:0] rd_data,
  output logic [spi_bank_pkg::ADDR_W-1:0] rd_addr,
  output logic                            rx_wr,
  output logic [spi_bank_pkg::ADDR_W-1:0] rx_addr,
  output logic [spi_bank_pkg::DATA_W-1:0] rx_data,
  output logic                            miso_int
);
  import spi_bank_pkg::*;

  // room to count past a full frame, saturates
  localparam int CNT_W = $clog2(FRAME_BITS) + 2;

  logic [2:0]            ss_q;
  logic [2:0]            sclk_q;
  logic [1:0]            mosi_q;
  logic                  ss_s;
  logic                  mosi_s;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  ss_rise;
  logic [FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]      bit_cnt;
  logic [ADDR_W-1:0]     addr_q;
  logic                  ld_tx;
  logic [DATA_W-1:0]     tx_q;

  ////////////////////////////////////////
  // pin synchronizers

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      // ss idles high, so no false rise out of reset
      ss_q   <= '1;
      sclk_q <= '0;
      mosi_q <= '0;
    end
    else
    begin
      ss_q   <= {ss_q[1:0], spi_ss};
      sclk_q <= {sclk_q[1:0], spi_sclk};
      mosi_q <= {mosi_q[0], spi_mosi};
    end
  end

  // stage 1 is the synchronized level, stage 2 the previous one
  assign ss_s      = ss_q[1];
  assign mosi_s    = mosi_q[1];
  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign ss_rise   = ss_q[1] & ~ss_q[2];

  ////////////////////////////////////////
  // bit count and frame shift

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      ld_tx   <= 1'b0;
    end
    else
    begin
      ld_tx <= 1'b0;
      if (ss_s)
        bit_cnt <= '0;
      else if (sclk_rise)
      begin
        if (bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;
        // eighth rise, readback load next cycle
        ld_tx <= (bit_cnt == CNT_W'(ADDR_W - 1));
      end
    end
  end

  always_ff @(posedge cs)
  begin
    if (!ss_s && sclk_rise)
    begin
      shift_q <= {shift_q[FRAME_BITS-2:0], mosi_s};
      // address byte complete with this bit
      if (bit_cnt == CNT_W'(ADDR_W - 1))
        addr_q <= {shift_q[ADDR_W-2:0], mosi_s};
    end
  end

  assign rd_addr = addr_q;

  ////////////////////////////////////////
  // frame end

  // short or long frames never write
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      rx_wr <= 1'b0;
    else
      rx_wr <= ss_rise && (bit_cnt == CNT_W'(FRAME_BITS));
  end

  // held until the next good frame
  always_ff @(posedge cs)
  begin
    if (ss_rise && (bit_cnt == CNT_W'(FRAME_BITS)))
    begin
      rx_addr <= shift_q[FRAME_BITS-1 -: ADDR_W];
      rx_data <= shift_q[DATA_W-1:0];
    end
  end

  ////////////////////////////////////////
  // readback shifter

  always_ff @(posedge cs)
  begin
    if (!rst_n)
      tx_q <= '0;
    else if (ss_s)
      tx_q <= '0;
    else if (ld_tx)
      tx_q <= rd_data;
    // host samples on rise, so advance on fall
    else if (sclk_fall)
      tx_q <= {tx_q[DATA_W-2:0], 1'b0};
  end

  // msb first, zero fill
  assign miso_int = tx_q[DATA_W-1];

  // write only lands after the host has released ss for good
  a_wr_ss_high: assert property (@(posedge cs) disable iff (!rst_n)
    rx_wr |-> ss_q[1] && $past(ss_q[1]))
    else $error("rx_wr while spi_ss low");

endmodule

//--- source/spi_bank_pkg.sv
/* shared constants for the board-control register bank
   frame widths, register addresses, command codes and reset values
   used by the SPI frame receiver, the write arbiter and the bank */
package spi_bank_pkg;

  ////////////////////////////////////////
  // frame layout

  // address byte then value byte, msb first
  localparam int ADDR_W = 8;
  localparam int DATA_W = 8;
  localparam int FRAME_BITS = ADDR_W + DATA_W;

  // update registers are one nibble
  // low nibble of value sets, high nibble clears
  localparam int NIB_W = 4;

  ////////////////////////////////////////
  // register addresses

  localparam logic [ADDR_W-1:0] REG_LED = 8'd7;
  localparam logic [ADDR_W-1:0] REG_SPI_MUX = 8'd8;
  localparam logic [ADDR_W-1:0] REG_4094 = 8'd9;
  localparam logic [ADDR_W-1:0] REG_ADC = 8'd14;

  ////////////////////////////////////////
  // command addresses

  // value byte ignored for commands
  // powerup clears led and adc only
  localparam logic [ADDR_W-1:0] CMD_POWERUP = 8'd6;

  // soft reset clears led, adc, 4094 and mux
  localparam logic [ADDR_W-1:0] CMD_SOFT_RESET = 8'd11;

  ////////////////////////////////////////
  // reset values

  // led 0 lit out of reset
  localparam logic [NIB_W-1:0] LED_RESET = 4'b0001;

endpackage
